//--- common/aud_sample_pkg.sv
package aud_sample_pkg;

    // one mono pcm word, two's complement
    typedef logic signed [15:0] sample_t;

    // raw speed field, factor is value + 1
    typedef logic [2:0] speed_t;

    // hold / interpolation step, runs 1..8
    typedef logic [3:0] step_t;

    // interpolation accumulator
    // 16b sample times 8 still fits with sign
    typedef logic signed [19:0] acc_t;

endpackage

//--- common/aud_ctrl_pkg.sv
package aud_ctrl_pkg;

    // playback control state
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_PLAY  = 2'd1,
        ST_PAUSE = 2'd2
    } play_state_e;

    // rate mode, latched at start
    typedef enum logic [1:0] {
        RATE_NORMAL = 2'd0,  // every sample once
        RATE_FAST   = 2'd1,  // skip by N
        RATE_HOLD   = 2'd2,  // repeat N times
        RATE_INTERP = 2'd3   // linear steps between neighbours
    } rate_mode_e;

endpackage

//--- hdl/sample_store.sv
`timescale 1ns/10ps

module sample_store #(
    parameter int ADDR_W = 10
) (
    input  logic                    i_clk,
    input  logic                    i_wr_en,
    input  logic [ADDR_W-1:0]       i_wr_addr,
    input  aud_sample_pkg::sample_t i_wr_data,
    input  logic                    i_rd_en,
    input  logic [ADDR_W-1:0]       i_rd_addr,
    output aud_sample_pkg::sample_t o_rd_data
);

    localparam int DEPTH = 2 ** ADDR_W;

    aud_sample_pkg::sample_t mem [DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // data one cycle after the read strobe
    always_ff @(posedge i_clk) begin
        if (i_rd_en) begin
            o_rd_data <= mem[i_rd_addr];
        end
    end

endmodule

//--- aud_dsp/aud_dsp.sv
`timescale 1ns/10ps

module aud_dsp #(
    parameter int ADDR_W  = 10,
    parameter int CREDITS = 2
) (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_start,
    input  logic                        i_pause,
    input  logic                        i_stop,
    input  aud_ctrl_pkg::rate_mode_e    i_mode,
    input  aud_sample_pkg::speed_t      i_speed,
    input  logic [ADDR_W-1:0]           i_stop_addr,
    output logic                        o_rd_en,
    output logic [ADDR_W-1:0]           o_rd_addr,
    input  aud_sample_pkg::sample_t     i_rd_data,
    output logic                        o_smp_valid,
    output aud_sample_pkg::sample_t     o_smp_data,
    input  logic                        i_credit,
    output aud_ctrl_pkg::play_state_e   o_state,
    output logic                        o_fin
);

    localparam int CW = $clog2(CREDITS + 1);

    aud_ctrl_pkg::play_state_e state_r, state_nx;
    aud_ctrl_pkg::rate_mode_e  mode_r;
    aud_sample_pkg::step_t     n_r;       // speed factor N
    aud_sample_pkg::step_t     step_r;    // k, 1..N
    aud_sample_pkg::sample_t   prev_r;
    aud_sample_pkg::sample_t   result;
    aud_sample_pkg::acc_t      mix;
    logic [ADDR_W-1:0]         addr_r;
    logic [ADDR_W:0]           stride;
    logic [ADDR_W:0]           next_addr;  // one extra bit so it cannot wrap
    logic [CW-1:0]             cred_r;
    logic                      rd_pend;    // read issued last cycle
    logic                      fetch;
    logic                      last_step;
    logic                      done;
    logic                      fin_nx;

    assign fetch = (state_r == aud_ctrl_pkg::ST_PLAY) && !i_stop && (cred_r != '0)
                   && !rd_pend && !o_smp_valid;

    assign o_rd_en   = fetch;
    assign o_rd_addr = addr_r;
    assign o_state   = state_r;

    // normal and fast finish a sample in one emit
    assign last_step = (mode_r == aud_ctrl_pkg::RATE_NORMAL) ||
                       (mode_r == aud_ctrl_pkg::RATE_FAST) || (step_r == n_r);

    assign stride    = (mode_r == aud_ctrl_pkg::RATE_FAST) ? (ADDR_W+1)'(n_r)
                                                           : (ADDR_W+1)'(1);
    assign next_addr = {1'b0, addr_r} + stride;
    assign done      = rd_pend && last_step && (next_addr >= {1'b0, i_stop_addr});

    // cur*k + prev*(N-k), signed divide truncates toward zero
    assign mix = aud_sample_pkg::acc_t'(i_rd_data) * aud_sample_pkg::acc_t'(step_r)
               + aud_sample_pkg::acc_t'(prev_r) * aud_sample_pkg::acc_t'(n_r - step_r);

    always_comb begin
        if (mode_r == aud_ctrl_pkg::RATE_INTERP) begin
            result = aud_sample_pkg::sample_t'(mix / aud_sample_pkg::acc_t'(n_r));
        end else begin
            result = i_rd_data;
        end
    end

    always_comb begin
        state_nx = state_r;
        case (state_r)
            aud_ctrl_pkg::ST_IDLE: begin
                if (i_start) state_nx = aud_ctrl_pkg::ST_PLAY;
            end
            aud_ctrl_pkg::ST_PLAY: begin
                if (i_stop || done) begin
                    state_nx = aud_ctrl_pkg::ST_IDLE;
                end else if (i_pause) begin
                    state_nx = aud_ctrl_pkg::ST_PAUSE;
                end
            end
            aud_ctrl_pkg::ST_PAUSE: begin
                // an in-flight read still lands while paused
                if (i_stop || done) begin
                    state_nx = aud_ctrl_pkg::ST_IDLE;
                end else if (i_start) begin
                    state_nx = aud_ctrl_pkg::ST_PLAY;
                end
            end
            default: state_nx = aud_ctrl_pkg::ST_IDLE;
        endcase
    end

    assign fin_nx = (state_r != aud_ctrl_pkg::ST_IDLE) && (state_nx == aud_ctrl_pkg::ST_IDLE);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r     <= aud_ctrl_pkg::ST_IDLE;
            o_fin       <= 1'b0;
            rd_pend     <= 1'b0;
            o_smp_valid <= 1'b0;
            cred_r      <= CW'(CREDITS);
            mode_r      <= aud_ctrl_pkg::RATE_NORMAL;
            n_r         <= 4'd1;
            step_r      <= 4'd1;
            addr_r      <= '0;
            prev_r      <= '0;
        end else begin
            state_r     <= state_nx;
            o_fin       <= fin_nx;
            rd_pend     <= fetch;
            o_smp_valid <= rd_pend && !i_stop;   // stop drops the in-flight read
            cred_r      <= cred_r + CW'(i_credit) - CW'(o_smp_valid);

            if (state_r == aud_ctrl_pkg::ST_IDLE && i_start) begin
                mode_r <= i_mode;
                n_r    <= aud_sample_pkg::step_t'(i_speed) + 4'd1;
                step_r <= 4'd1;
                addr_r <= '0;
                prev_r <= '0;
            end else if (rd_pend && !i_stop) begin
                if (last_step) begin
                    addr_r <= next_addr[ADDR_W-1:0];
                    step_r <= 4'd1;
                    if (mode_r == aud_ctrl_pkg::RATE_INTERP) prev_r <= i_rd_data;
                end else begin
                    step_r <= step_r + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (rd_pend) begin
            o_smp_data <= result;
        end
    end

endmodule

//--- dac_tx/dac_tx.sv
`timescale 1ns/10ps

module dac_tx #(
    parameter int CREDITS  = 2,
    parameter int BCLK_DIV = 2
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_smp_valid,
    input  aud_sample_pkg::sample_t i_smp_data,
    output logic                    o_credit,
    output logic                    o_bclk,
    output logic                    o_lrck,
    output logic                    o_sd
);

    localparam int PW = (CREDITS > 1) ? $clog2(CREDITS) : 1;
    localparam int CW = $clog2(CREDITS + 1);
    localparam int DW = (BCLK_DIV > 1) ? $clog2(BCLK_DIV) : 1;

    aud_sample_pkg::sample_t q_mem [CREDITS];
    aud_sample_pkg::sample_t hold_r;     // kept for the right channel
    aud_sample_pkg::sample_t word;
    logic [15:0]             shreg;
    logic [PW-1:0]           wr_ptr, rd_ptr;
    logic [CW-1:0]           q_cnt;
    logic [DW-1:0]           div_cnt;
    logic [4:0]              bit_cnt;
    logic                    tick, fall, frame_end, pop;

    assign tick      = (div_cnt == DW'(BCLK_DIV - 1));
    assign fall      = tick && o_bclk;
    assign frame_end = fall && (bit_cnt == 5'd31);
    assign pop       = frame_end && (q_cnt != '0);
    assign word      = pop ? q_mem[rd_ptr] : '0;   // underrun sends silence

    // queue storage, never written while full
    always_ff @(posedge i_clk) begin
        if (i_smp_valid) begin
            q_mem[wr_ptr] <= i_smp_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            q_cnt    <= '0;
            o_credit <= 1'b0;
        end else begin
            if (i_smp_valid) begin
                wr_ptr <= (wr_ptr == PW'(CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            q_cnt    <= q_cnt + CW'(i_smp_valid) - CW'(pop);
            o_credit <= pop;   // one credit per sample taken
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            div_cnt <= '0;
            o_bclk  <= 1'b0;
        end else if (tick) begin
            div_cnt <= '0;
            o_bclk  <= ~o_bclk;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // serializer, everything moves on the bclk falling edge
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bit_cnt <= '0;
            o_lrck  <= 1'b0;
            o_sd    <= 1'b0;
            shreg   <= '0;
            hold_r  <= '0;
        end else if (fall) begin
            bit_cnt <= bit_cnt + 5'd1;
            if (frame_end) begin
                hold_r <= word;
                o_lrck <= 1'b0;   // left half
                o_sd   <= word[15];
                shreg  <= {word[14:0], 1'b0};
            end else if (bit_cnt == 5'd15) begin
                o_lrck <= 1'b1;
                o_sd   <= hold_r[15];
                shreg  <= {hold_r[14:0], 1'b0};
            end else begin
                o_sd  <= shreg[15];
                shreg <= {shreg[14:0], 1'b0};
            end
        end
    end

endmodule

//--- hdl/aud_player_top.sv
`timescale 1ns/10ps

module aud_player_top #(
    parameter int ADDR_W   = 10,
    parameter int CREDITS  = 2,
    parameter int BCLK_DIV = 2
) (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_wr_en,
    input  logic [ADDR_W-1:0]         i_wr_addr,
    input  aud_sample_pkg::sample_t   i_wr_data,
    input  logic                      i_start,
    input  logic                      i_pause,
    input  logic                      i_stop,
    input  aud_ctrl_pkg::rate_mode_e  i_mode,
    input  aud_sample_pkg::speed_t    i_speed,
    input  logic [ADDR_W-1:0]         i_stop_addr,
    output aud_ctrl_pkg::play_state_e o_state,
    output logic                      o_fin,
    output logic                      o_dac_bclk,
    output logic                      o_dac_lrck,
    output logic                      o_dac_sd
);

    logic                    rd_en;
    logic [ADDR_W-1:0]       rd_addr;
    aud_sample_pkg::sample_t rd_data;
    logic                    smp_valid;
    aud_sample_pkg::sample_t smp_data;
    logic                    credit;

    sample_store #(
        .ADDR_W (ADDR_W)
    ) sample_store_i (
        .i_clk     (i_clk),
        .i_wr_en   (i_wr_en),
        .i_wr_addr (i_wr_addr),
        .i_wr_data (i_wr_data),
        .i_rd_en   (rd_en),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data)
    );

    aud_dsp #(
        .ADDR_W  (ADDR_W),
        .CREDITS (CREDITS)
    ) aud_dsp_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_pause     (i_pause),
        .i_stop      (i_stop),
        .i_mode      (i_mode),
        .i_speed     (i_speed),
        .i_stop_addr (i_stop_addr),
        .o_rd_en     (rd_en),
        .o_rd_addr   (rd_addr),
        .i_rd_data   (rd_data),
        .o_smp_valid (smp_valid),
        .o_smp_data  (smp_data),
        .i_credit    (credit),
        .o_state     (o_state),
        .o_fin       (o_fin)
    );

    dac_tx #(
        .CREDITS  (CREDITS),
        .BCLK_DIV (BCLK_DIV)
    ) dac_tx_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_smp_valid (smp_valid),
        .i_smp_data  (smp_data),
        .o_credit    (credit),
        .o_bclk      (o_dac_bclk),
        .o_lrck      (o_dac_lrck),
        .o_sd        (o_dac_sd)
    );

endmodule

//--- sim/aud_player_checker.sv
`timescale 1ns/10ps

module aud_player_checker #(
    parameter int CREDITS = 2
) (
    input logic                        i_clk,
    input logic                        i_rst_n,
    input logic [$clog2(CREDITS+1)-1:0] i_cred,
    input logic                        i_smp_valid,
    input logic                        i_fin,
    input logic                        i_rd_en,
    input aud_ctrl_pkg::play_state_e   i_state,
    input aud_sample_pkg::step_t       i_step,
    input aud_sample_pkg::step_t       i_n
);

    int fails = 0;

    a_cred_max: assert property (@(posedge i_clk) disable iff (!i_rst_n) i_cred <= CREDITS)
        else begin
            $error("credit count above queue depth");
            fails++;
        end

    a_valid_cred: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_smp_valid |-> (i_cred != '0))
        else begin
            $error("sample sent with no credit left");
            fails++;
        end

    a_fin_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n) i_fin |=> !i_fin)
        else begin
            $error("fin held longer than one cycle");
            fails++;
        end

    a_rd_play: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_rd_en |-> (i_state == aud_ctrl_pkg::ST_PLAY))
        else begin
            $error("memory read outside playback");
            fails++;
        end

    // step k stays within 1..N
    a_step_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_step >= 4'd1) && (i_step <= i_n))
        else begin
            $error("interpolation step out of range");
            fails++;
        end

endmodule

bind aud_dsp aud_player_checker #(
    .CREDITS (CREDITS)
) aud_player_checker_i (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_cred      (cred_r),
    .i_smp_valid (o_smp_valid),
    .i_fin       (o_fin),
    .i_rd_en     (o_rd_en),
    .i_state     (o_state),
    .i_step      (step_r),
    .i_n         (n_r)
);

//--- sim/aud_player_tb.sv
`timescale 1ns/10ps

module aud_player_tb;

    localparam int ADDR_W    = 10;
    localparam int BCLK_DIV  = 2;
    localparam int IMG_WORDS = 64;

    logic                      i_clk;
    logic                      i_rst_n;
    logic                      i_wr_en;
    logic [ADDR_W-1:0]         i_wr_addr;
    aud_sample_pkg::sample_t   i_wr_data;
    logic                      i_start;
    logic                      i_pause;
    logic                      i_stop;
    aud_ctrl_pkg::rate_mode_e  i_mode;
    aud_sample_pkg::speed_t    i_speed;
    logic [ADDR_W-1:0]         i_stop_addr;
    aud_ctrl_pkg::play_state_e o_state;
    logic                      o_fin;
    logic                      o_dac_bclk;
    logic                      o_dac_lrck;
    logic                      o_dac_sd;

    aud_sample_pkg::sample_t img [IMG_WORDS];
    aud_sample_pkg::sample_t exp_q [$];
    aud_sample_pkg::sample_t left_w = '0;
    aud_sample_pkg::sample_t right_w = '0;
    integer seed = 32'hfc9d_a196;
    string  test_name = "none";
    int     errors = 0;
    int     tests = 0;
    int     rx_idx = 0;
    int     fin_cnt = 0;
    int     r_bits = 0;
    int     cycles = 0;
    int     limit = 0;

    aud_player_top aud_player_top_i (.*);

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    // expected nonzero words of one playback
    function automatic int model_samples(input aud_ctrl_pkg::rate_mode_e mode,
                                         input aud_sample_pkg::speed_t speed,
                                         input int stop_addr);
        int n;
        int a;
        int stride;
        int reps;
        int acc;
        aud_sample_pkg::sample_t prev;
        aud_sample_pkg::sample_t cur;
        aud_sample_pkg::sample_t val;
        exp_q.delete();
        n = int'(speed) + 1;
        stride = (mode == aud_ctrl_pkg::RATE_FAST) ? n : 1;
        reps = (mode == aud_ctrl_pkg::RATE_HOLD || mode == aud_ctrl_pkg::RATE_INTERP) ? n : 1;
        prev = '0;
        a = 0;
        do begin
            cur = img[a];
            for (int k = 1; k <= reps; k++) begin
                if (mode == aud_ctrl_pkg::RATE_INTERP) begin
                    acc = int'(cur) * k + int'(prev) * (n - k);
                    val = aud_sample_pkg::sample_t'(acc / n);  // int divide truncates to zero
                end else begin
                    val = cur;
                end
                if (val != 0) exp_q.push_back(val);
            end
            prev = cur;
            a += stride;
        end while (a < stop_addr);
        return exp_q.size();
    endfunction

    function automatic int test_cycles(input int words);
        return (words + 4) * 32 * 2 * BCLK_DIV + 200;  // frames plus latency and drain
    endfunction

    task automatic check_sample(input string what, input aud_sample_pkg::sample_t exp,
                                input aud_sample_pkg::sample_t act);
        if (act !== exp) begin
            $display("Error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_fin(input int exp, input int act);
        if (act != exp) begin
            $display("Error %s fin pulses: expected %0d, actual %0d", test_name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input int exp, input int act);
        if (act != exp) begin
            $display("Error %s word count: expected %0d, actual %0d", test_name, exp, act);
            errors++;
        end
    endtask

    task automatic check_state(input aud_ctrl_pkg::play_state_e exp,
                               input aud_ctrl_pkg::play_state_e act);
        if (act !== exp) begin
            $display("Error %s state: expected %s, actual %s", test_name, exp.name(),
                     act.name());
            errors++;
        end
    endtask

    task automatic compare_frame();
        if (rx_idx < exp_q.size()) begin
            check_sample($sformatf("left word %0d", rx_idx), exp_q[rx_idx], left_w);
            check_sample($sformatf("right word %0d", rx_idx), exp_q[rx_idx], right_w);
        end else begin
            $display("%s: unexpected extra word %0d after the end of the list", test_name,
                     left_w);
            errors++;
        end
        rx_idx++;
    endtask

    // deserializer samples sd on the bclk rising edge
    always @(posedge o_dac_bclk) begin
        if (!o_dac_lrck) begin
            left_w = {left_w[14:0], o_dac_sd};
        end else begin
            right_w = {right_w[14:0], o_dac_sd};
            r_bits++;
            if (r_bits == 16) begin
                r_bits = 0;
                if (left_w != 0 || right_w != 0) compare_frame();
            end
        end
    end

    always @(negedge i_clk) begin
        if (o_fin) fin_cnt++;
    end

    initial begin
        while (limit == 0 || cycles <= limit) begin
            @(posedge i_clk);
            cycles++;
        end
        $display("timeout after %0d cycles, playback never completed", cycles);
        $display("Result: FAILED");
        $finish;
    end

    task automatic load_memory();
        int r;
        for (int a = 0; a < IMG_WORDS; a++) begin
            r = $random(seed);
            img[a] = aud_sample_pkg::sample_t'((r & 32'h7fff_ffff) % 16383 + 1);
            @(negedge i_clk);
            i_wr_en = 1'b1;
            i_wr_addr = ADDR_W'(a);
            i_wr_data = img[a];
        end
        @(negedge i_clk);
        i_wr_en = 1'b0;
    endtask

    task automatic start_playback(input string name, input aud_ctrl_pkg::rate_mode_e mode,
                                  input aud_sample_pkg::speed_t speed, input int stop_addr,
                                  output int n_exp);
        test_name = name;
        n_exp = model_samples(mode, speed, stop_addr);
        rx_idx = 0;
        fin_cnt = 0;
        @(negedge i_clk);
        i_mode = mode;
        i_speed = speed;
        i_stop_addr = ADDR_W'(stop_addr);
        i_start = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
    endtask

    task automatic report_test(input int err_start);
        tests++;
        $display("test %s: %0d words, %0d errors", test_name, rx_idx, errors - err_start);
    endtask

    task automatic finish_playback(input int n_exp, input int err_start);
        while (fin_cnt == 0) @(negedge i_clk);
        while (rx_idx < n_exp) @(negedge i_clk);
        repeat (2) @(negedge o_dac_lrck);
        check_count(n_exp, rx_idx);
        check_fin(1, fin_cnt);
        check_state(aud_ctrl_pkg::ST_IDLE, o_state);
        report_test(err_start);
    endtask

    task automatic run_playback(input string name, input aud_ctrl_pkg::rate_mode_e mode,
                                input aud_sample_pkg::speed_t speed, input int stop_addr);
        int n_exp;
        int err_start;
        err_start = errors;
        start_playback(name, mode, speed, stop_addr, n_exp);
        finish_playback(n_exp, err_start);
    endtask

    task automatic pause_resume();
        int n_exp;
        int err_start;
        err_start = errors;
        start_playback("pause", aud_ctrl_pkg::RATE_HOLD, 3'd3, 8, n_exp);
        while (rx_idx < 6) @(negedge i_clk);
        i_pause = 1'b1;
        @(negedge i_clk);
        i_pause = 1'b0;
        check_state(aud_ctrl_pkg::ST_PAUSE, o_state);
        repeat (4) @(negedge o_dac_lrck);  // queue drains into silence
        check_state(aud_ctrl_pkg::ST_PAUSE, o_state);
        check_fin(0, fin_cnt);
        @(negedge i_clk);
        i_start = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
        finish_playback(n_exp, err_start);
    endtask

    task automatic stop_early();
        int n_exp;
        int err_start;
        err_start = errors;
        start_playback("stop", aud_ctrl_pkg::RATE_NORMAL, 3'd0, 40, n_exp);
        while (rx_idx < 5) @(negedge i_clk);
        i_stop = 1'b1;
        @(negedge i_clk);
        i_stop = 1'b0;
        repeat (3) @(negedge o_dac_lrck);
        check_fin(1, fin_cnt);
        check_state(aud_ctrl_pkg::ST_IDLE, o_state);
        if (rx_idx >= n_exp) begin
            $display("%s: stop did not cut the run short, all %0d words arrived", test_name,
                     rx_idx);
            errors++;
        end
        report_test(err_start);
    endtask

    initial begin
        i_rst_n = 1'b0;
        i_wr_en = 1'b0;
        i_wr_addr = '0;
        i_wr_data = '0;
        i_start = 1'b0;
        i_pause = 1'b0;
        i_stop = 1'b0;
        i_mode = aud_ctrl_pkg::RATE_NORMAL;
        i_speed = '0;
        i_stop_addr = '0;
        repeat (5) @(negedge i_clk);
        i_rst_n = 1'b1;
        load_memory();
        limit = cycles + 200
              + test_cycles(model_samples(aud_ctrl_pkg::RATE_NORMAL, 3'd0, 12))
              + test_cycles(model_samples(aud_ctrl_pkg::RATE_FAST, 3'd2, 14))
              + test_cycles(model_samples(aud_ctrl_pkg::RATE_HOLD, 3'd3, 6))
              + test_cycles(model_samples(aud_ctrl_pkg::RATE_INTERP, 3'd1, 10))
              + test_cycles(model_samples(aud_ctrl_pkg::RATE_HOLD, 3'd3, 8) + 4)
              + test_cycles(model_samples(aud_ctrl_pkg::RATE_NORMAL, 3'd0, 40));
        run_playback("normal", aud_ctrl_pkg::RATE_NORMAL, 3'd0, 12);
        run_playback("fast", aud_ctrl_pkg::RATE_FAST, 3'd2, 14);
        run_playback("hold", aud_ctrl_pkg::RATE_HOLD, 3'd3, 6);
        run_playback("interp", aud_ctrl_pkg::RATE_INTERP, 3'd1, 10);
        pause_resume();
        stop_early();
        errors += aud_player_top_i.aud_dsp_i.aud_player_checker_i.fails;
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
common/aud_sample_pkg.sv
common/aud_ctrl_pkg.sv
hdl/sample_store.sv
aud_dsp/aud_dsp.sv
dac_tx/dac_tx.sv
hdl/aud_player_top.sv
sim/aud_player_checker.sv
sim/aud_player_tb.sv
